// ==== include/core_settings.svh ====
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// datapath width and shift amount
`define CORE_XLEN        64
`define CORE_SHAMT_W     6

// register file address width, 32 entries
`define CORE_REG_AW      5

// instruction address, 256 words
`define CORE_PC_W        8

// special read addresses, selected by one address bit each
`define CORE_STATUS_BIT  8
`define CORE_RDPTR_BIT   9

// widths of the special registers before zero extension
`define CORE_STATUS_W    2
`define CORE_RDPTR_W     8

`endif

// ==== logic/isa_pkg.sv ====
`default_nettype none

package isa_pkg;

   // major opcodes, bits 6:0 of the instruction word
   typedef enum logic [6:0] {
      opc_alu_reg = 7'b0110011,
      opc_alu_imm = 7'b0010011,
      opc_load    = 7'b0000011,
      opc_store   = 7'b0100011,
      opc_branch  = 7'b1100011,
      opc_jal     = 7'b1101111
   } opcode_e;

   // funct3 of the alu forms
   // sub and sra share codes with add and srl, funct7 bit picks
   typedef enum logic [2:0] {
      alu_add  = 3'b000,
      alu_sll  = 3'b001,
      alu_slt  = 3'b010,
      alu_sltu = 3'b011,
      alu_xor  = 3'b100,
      alu_srl  = 3'b101,
      alu_or   = 3'b110,
      alu_and  = 3'b111
   } alu_op_e;

   // funct3 of the branch forms
   typedef enum logic [2:0] {
      br_eq  = 3'b000,
      br_ne  = 3'b001,
      br_lt  = 3'b100,
      br_ge  = 3'b101,
      br_ltu = 3'b110,
      br_geu = 3'b111
   } branch_op_e;

   // decoded controls, all zero for a bubble
   typedef struct packed {
      logic reg_write;
      logic mem_write;
      logic mem_to_reg;
      logic use_imm;
      logic is_branch;
      logic is_jal;
   } ctrl_t;

endpackage

`default_nettype wire

// ==== logic/pipe_pkg.sv ====
`default_nettype none

`include "core_settings.svh"

package pipe_pkg;

   // -------------------------------------------------------------------------
   // decode to execute
   // -------------------------------------------------------------------------
   typedef struct packed {
      isa_pkg::ctrl_t           ctrl;
      logic [`CORE_XLEN-1:0]    rs1_val;
      logic [`CORE_XLEN-1:0]    rs2_val;
      // I form, or S form for stores
      logic [`CORE_XLEN-1:0]    imm;
      logic [`CORE_REG_AW-1:0]  rd;
      // forced to add for loads and stores
      isa_pkg::alu_op_e         funct3;
      // instruction bit 30
      logic                     funct7;
      logic [`CORE_PC_W-1:0]    pc;
   } id_ex_t;

   // -------------------------------------------------------------------------
   // execute to memory side
   // -------------------------------------------------------------------------
   typedef struct packed {
      logic                     reg_write;
      logic                     mem_write;
      logic                     mem_to_reg;
      // also the data address
      logic [`CORE_XLEN-1:0]    alu_result;
      logic [`CORE_XLEN-1:0]    store_data;
      logic [`CORE_REG_AW-1:0]  rd;
      logic [`CORE_PC_W-1:0]    pc;
   } ex_mem_t;

endpackage

`default_nettype wire

// ==== logic/mem_stage_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// EX/MEM register contents on their way to the memory side
// one payload every cycle, no handshake
// bubble has reg_write and mem_write low
interface mem_stage_if;

   pipe_pkg::ex_mem_t payload;

   // execute owns the register
   modport source (
      output payload
   );

   // writeback only looks at it
   modport sink (
      input  payload
   );

endinterface

`default_nettype wire

// ==== logic/fetch_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "core_settings.svh"

module fetch_unit (
   input  wire                     clk,
   input  wire                     reset,
   input  wire                     redirect_i,
   input  wire  [`CORE_PC_W-1:0]   target_i,
   output logic [`CORE_PC_W-1:0]   imem_addr_o
);

   logic [`CORE_PC_W-1:0] pc_q;
   logic [`CORE_PC_W-1:0] pc_plus_one;

   // sequential flow, wraps at the top of the rom
   assign pc_plus_one = pc_q + 1'b1;

   // program counter
   // redirect comes from decode, one word behind this address
   always_ff @(posedge clk) begin
      if (reset) begin
         pc_q <= '0;
      end else if (redirect_i) begin
         pc_q <= target_i;
      end else begin
         pc_q <= pc_plus_one;
      end
   end

   // rom sees the pc directly, data comes back next cycle
   assign imem_addr_o = pc_q;

   // redirect lands on the target in the very next cycle
   a_redirect_target : assert property (@(posedge clk) disable iff (reset)
      redirect_i |=> imem_addr_o == $past(target_i));

endmodule

`default_nettype wire

// ==== logic/register_file.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "core_settings.svh"

module register_file (
   input  wire                      clk,
   input  wire                      we_i,
   input  wire  [`CORE_REG_AW-1:0]  waddr_i,
   input  wire  [`CORE_XLEN-1:0]    wdata_i,
   input  wire  [`CORE_REG_AW-1:0]  raddr1_i,
   input  wire  [`CORE_REG_AW-1:0]  raddr2_i,
   output logic [`CORE_XLEN-1:0]    rdata1_o,
   output logic [`CORE_XLEN-1:0]    rdata2_o
);

   logic [`CORE_XLEN-1:0] regs [2**`CORE_REG_AW];

   // one read port
   // x0 is hardwired
   // a write in flight bypasses the array
   function automatic logic [`CORE_XLEN-1:0] read_port(input logic [`CORE_REG_AW-1:0] addr);
      logic [`CORE_XLEN-1:0] value;
      if (addr == '0) begin
         value = '0;
      end else if (we_i && (waddr_i == addr)) begin
         value = wdata_i;
      end else begin
         value = regs[addr];
      end
      return value;
   endfunction

   // writes to x0 are dropped
   always_ff @(posedge clk) begin
      if (we_i && (waddr_i != '0)) begin
         regs[waddr_i] <= wdata_i;
      end
   end

   // both read ports follow the array and the write port
   always_comb begin
      rdata1_o = read_port(raddr1_i);
      rdata2_o = read_port(raddr2_i);
   end

endmodule

`default_nettype wire

// ==== logic/decode_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "core_settings.svh"

module decode_stage (
   input  wire                      clk,
   input  wire                      reset,
   input  wire  [31:0]              instr_i,
   input  wire  [`CORE_PC_W-1:0]    pc_i,
   output logic                     redirect_o,
   output logic [`CORE_PC_W-1:0]    target_o,
   input  wire                      wb_we_i,
   input  wire  [`CORE_REG_AW-1:0]  wb_addr_i,
   input  wire  [`CORE_XLEN-1:0]    wb_data_i,
   output pipe_pkg::id_ex_t         id_ex_o
);

   logic [`CORE_PC_W-1:0]  pc_q;
   logic                   squash_q;
   isa_pkg::ctrl_t         ctrl_raw;
   isa_pkg::ctrl_t         ctrl;
   logic [`CORE_XLEN-1:0]  rs1_val;
   logic [`CORE_XLEN-1:0]  rs2_val;
   logic [`CORE_XLEN-1:0]  imm_i;
   logic [`CORE_XLEN-1:0]  imm_s;
   logic [`CORE_XLEN-1:0]  off_b;
   logic [`CORE_XLEN-1:0]  off_j;
   logic                   taken;
   pipe_pkg::id_ex_t       id_ex_d;

   // word on instr_i belongs to last cycle's fetch address
   always_ff @(posedge clk) begin
      pc_q <= pc_i;
   end

   // kill the word fetched behind a redirect
   // also the stale word seen right out of reset
   always_ff @(posedge clk) begin
      if (reset) begin
         squash_q <= 1'b1;
      end else begin
         squash_q <= redirect_o;
      end
   end

   // -------------------------------------------------------------------------
   // control decode
   // -------------------------------------------------------------------------
   always_comb begin
      ctrl_raw = '0;
      case (instr_i[6:0])
         isa_pkg::opc_alu_reg: ctrl_raw.reg_write = 1'b1;
         isa_pkg::opc_alu_imm: begin
            ctrl_raw.reg_write = 1'b1;
            ctrl_raw.use_imm   = 1'b1;
         end
         isa_pkg::opc_load: begin
            ctrl_raw.reg_write  = 1'b1;
            ctrl_raw.mem_to_reg = 1'b1;
            ctrl_raw.use_imm    = 1'b1;
         end
         isa_pkg::opc_store: begin
            ctrl_raw.mem_write = 1'b1;
            ctrl_raw.use_imm   = 1'b1;
         end
         isa_pkg::opc_branch: ctrl_raw.is_branch = 1'b1;
         // jal only jumps, no link
         isa_pkg::opc_jal: ctrl_raw.is_jal = 1'b1;
         default: ctrl_raw = '0;
      endcase
   end

   assign ctrl = squash_q ? isa_pkg::ctrl_t'('0) : ctrl_raw;

   register_file u_regs (
      .clk      (clk),
      .we_i     (wb_we_i),
      .waddr_i  (wb_addr_i),
      .wdata_i  (wb_data_i),
      .raddr1_i (instr_i[19:15]),
      .raddr2_i (instr_i[24:20]),
      .rdata1_o (rs1_val),
      .rdata2_o (rs2_val)
   );

   // immediates, sign extended to xlen
   assign imm_i = {{(`CORE_XLEN-12){instr_i[31]}}, instr_i[31:20]};
   assign imm_s = {{(`CORE_XLEN-12){instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
   // branch and jump offsets in words, no implied zero bit
   assign off_b = {{(`CORE_XLEN-12){instr_i[31]}}, instr_i[31], instr_i[7],
                   instr_i[30:25], instr_i[11:8]};
   assign off_j = {{(`CORE_XLEN-20){instr_i[31]}}, instr_i[31], instr_i[19:12],
                   instr_i[20], instr_i[30:21]};

   // -------------------------------------------------------------------------
   // early branch resolution
   // -------------------------------------------------------------------------
   always_comb begin
      case (instr_i[14:12])
         isa_pkg::br_eq:  taken = (rs1_val == rs2_val);
         isa_pkg::br_ne:  taken = (rs1_val != rs2_val);
         isa_pkg::br_lt:  taken = ($signed(rs1_val) < $signed(rs2_val));
         isa_pkg::br_ge:  taken = ($signed(rs1_val) >= $signed(rs2_val));
         isa_pkg::br_ltu: taken = (rs1_val < rs2_val);
         isa_pkg::br_geu: taken = (rs1_val >= rs2_val);
         default:         taken = 1'b0;
      endcase
   end

   assign redirect_o = ctrl.is_jal | (ctrl.is_branch & taken);
   assign target_o   = pc_q + (ctrl.is_jal ? off_j[`CORE_PC_W-1:0] : off_b[`CORE_PC_W-1:0]);

   // ID/EX contents
   always_comb begin
      id_ex_d         = '0;
      id_ex_d.ctrl    = ctrl;
      id_ex_d.rs1_val = rs1_val;
      id_ex_d.rs2_val = rs2_val;
      id_ex_d.imm     = ctrl_raw.mem_write ? imm_s : imm_i;
      id_ex_d.rd      = instr_i[11:7];
      // address add for loads and stores
      id_ex_d.funct3  = ctrl_raw.use_imm && (ctrl_raw.mem_write || ctrl_raw.mem_to_reg) ?
                        isa_pkg::alu_add : isa_pkg::alu_op_e'(instr_i[14:12]);
      id_ex_d.funct7  = instr_i[30];
      id_ex_d.pc      = pc_q;
   end

   always_ff @(posedge clk) begin
      id_ex_o <= id_ex_d;
      if (reset) begin
         id_ex_o.ctrl <= '0;
      end
   end

   // the word behind a redirect is a bubble and never redirects itself
   a_squash_bubble : assert property (@(posedge clk) disable iff (reset)
      redirect_o |=> !redirect_o && (id_ex_d.ctrl == '0));

endmodule

`default_nettype wire

// ==== logic/execute_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "core_settings.svh"

module execute_stage (
   input  wire                 clk,
   input  wire                 reset,
   input  wire pipe_pkg::id_ex_t id_ex_i,
   mem_stage_if.source         ex_mem
);

   logic [`CORE_XLEN-1:0]    op_a;
   logic [`CORE_XLEN-1:0]    op_b;
   logic [`CORE_SHAMT_W-1:0] shamt;
   logic                     alt;
   logic [`CORE_XLEN-1:0]    result;
   pipe_pkg::ex_mem_t        ex_mem_d;

   // operand b, immediate for I and S forms
   assign op_a  = id_ex_i.rs1_val;
   assign op_b  = id_ex_i.ctrl.use_imm ? id_ex_i.imm : id_ex_i.rs2_val;
   assign shamt = op_b[`CORE_SHAMT_W-1:0];

   // sub and sra, register forms only
   assign alt = id_ex_i.funct7 & ~id_ex_i.ctrl.use_imm;

   // -------------------------------------------------------------------------
   // alu
   // -------------------------------------------------------------------------
   always_comb begin
      case (id_ex_i.funct3)
         isa_pkg::alu_add:  result = alt ? op_a - op_b : op_a + op_b;
         isa_pkg::alu_sll:  result = op_a << shamt;
         isa_pkg::alu_slt:  result = {{(`CORE_XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
         isa_pkg::alu_sltu: result = {{(`CORE_XLEN-1){1'b0}}, op_a < op_b};
         isa_pkg::alu_xor:  result = op_a ^ op_b;
         isa_pkg::alu_srl:  result = alt ? $unsigned($signed(op_a) >>> shamt) : op_a >> shamt;
         isa_pkg::alu_or:   result = op_a | op_b;
         default:           result = op_a & op_b;
      endcase
   end

   // EX/MEM contents
   always_comb begin
      ex_mem_d.reg_write  = id_ex_i.ctrl.reg_write;
      ex_mem_d.mem_write  = id_ex_i.ctrl.mem_write;
      ex_mem_d.mem_to_reg = id_ex_i.ctrl.mem_to_reg;
      ex_mem_d.alu_result = result;
      ex_mem_d.store_data = id_ex_i.rs2_val;
      ex_mem_d.rd         = id_ex_i.rd;
      ex_mem_d.pc         = id_ex_i.pc;
   end

   always_ff @(posedge clk) begin
      ex_mem.payload <= ex_mem_d;
      if (reset) begin
         ex_mem.payload.reg_write  <= 1'b0;
         ex_mem.payload.mem_write  <= 1'b0;
         ex_mem.payload.mem_to_reg <= 1'b0;
      end
   end

   // decode never marks one word as both load and store
   a_no_load_store : assert property (@(posedge clk) disable iff (reset)
      !(ex_mem.payload.mem_write && ex_mem.payload.mem_to_reg));

endmodule

`default_nettype wire

// ==== logic/writeback_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "core_settings.svh"

module writeback_stage (
   input  wire                       clk,
   input  wire                       reset,
   mem_stage_if.sink                 ex_mem,
   output logic                      dmem_we_o,
   output logic [`CORE_XLEN-1:0]     dmem_addr_o,
   output logic [`CORE_XLEN-1:0]     dmem_wdata_o,
   output logic [`CORE_PC_W-1:0]     dmem_pc_o,
   input  wire  [`CORE_XLEN-1:0]     dmem_rdata_i,
   input  wire  [`CORE_STATUS_W-1:0] state_status_i,
   input  wire  [`CORE_RDPTR_W-1:0]  read_ptr_i,
   output logic                      wb_we_o,
   output logic [`CORE_REG_AW-1:0]   wb_addr_o,
   output logic [`CORE_XLEN-1:0]     wb_data_o
);

   logic                     we_q;
   logic                     mem_to_reg_q;
   logic [`CORE_REG_AW-1:0]  rd_q;
   logic [`CORE_XLEN-1:0]    alu_q;
   logic [`CORE_XLEN-1:0]    load_val;

   // data port straight from EX/MEM
   assign dmem_we_o    = ex_mem.payload.mem_write;
   assign dmem_addr_o  = ex_mem.payload.alu_result;
   assign dmem_wdata_o = ex_mem.payload.store_data;
   assign dmem_pc_o    = ex_mem.payload.pc;

   // MEM/WB controls
   always_ff @(posedge clk) begin
      if (reset) begin
         we_q         <= 1'b0;
         mem_to_reg_q <= 1'b0;
      end else begin
         we_q         <= ex_mem.payload.reg_write;
         mem_to_reg_q <= ex_mem.payload.mem_to_reg;
      end
   end

   // MEM/WB payload, address kept for the load source select
   always_ff @(posedge clk) begin
      rd_q  <= ex_mem.payload.rd;
      alu_q <= ex_mem.payload.alu_result;
   end

   // load source, read data arrives this cycle
   // status wins over the read pointer
   always_comb begin
      if (alu_q[`CORE_STATUS_BIT]) begin
         load_val = {{(`CORE_XLEN-`CORE_STATUS_W){1'b0}}, state_status_i};
      end else if (alu_q[`CORE_RDPTR_BIT]) begin
         load_val = {{(`CORE_XLEN-`CORE_RDPTR_W){1'b0}}, read_ptr_i};
      end else begin
         load_val = dmem_rdata_i;
      end
   end

   assign wb_we_o   = we_q;
   assign wb_addr_o = rd_q;
   assign wb_data_o = mem_to_reg_q ? load_val : alu_q;

   // no write reaches the memory while the core is held in reset
   a_no_store_in_reset : assert property (@(posedge clk)
      $past(reset) |-> !dmem_we_o);

endmodule

`default_nettype wire

// ==== logic/core_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "core_settings.svh"

module core_top (
   input  wire                       clk,
   input  wire                       reset,
   // instruction rom, one cycle read
   output logic [`CORE_PC_W-1:0]     imem_addr_o,
   input  wire  [31:0]               imem_data_i,
   // data port, one cycle read
   output logic                      dmem_we_o,
   output logic [`CORE_XLEN-1:0]     dmem_addr_o,
   output logic [`CORE_XLEN-1:0]     dmem_wdata_o,
   output logic [`CORE_PC_W-1:0]     dmem_pc_o,
   input  wire  [`CORE_XLEN-1:0]     dmem_rdata_i,
   // special registers
   input  wire  [`CORE_STATUS_W-1:0] state_status_i,
   input  wire  [`CORE_RDPTR_W-1:0]  read_ptr_i
);

   logic                    redirect;
   logic [`CORE_PC_W-1:0]   target;
   pipe_pkg::id_ex_t        id_ex;
   logic                    wb_we;
   logic [`CORE_REG_AW-1:0] wb_addr;
   logic [`CORE_XLEN-1:0]   wb_data;

   mem_stage_if ex_mem_bus ();

   fetch_unit u_fetch (
      .clk         (clk),
      .reset       (reset),
      .redirect_i  (redirect),
      .target_i    (target),
      .imem_addr_o (imem_addr_o)
   );

   // decode tracks the fetch address itself
   decode_stage u_decode (
      .clk        (clk),
      .reset      (reset),
      .instr_i    (imem_data_i),
      .pc_i       (imem_addr_o),
      .redirect_o (redirect),
      .target_o   (target),
      .wb_we_i    (wb_we),
      .wb_addr_i  (wb_addr),
      .wb_data_i  (wb_data),
      .id_ex_o    (id_ex)
   );

   execute_stage u_execute (
      .clk     (clk),
      .reset   (reset),
      .id_ex_i (id_ex),
      .ex_mem  (ex_mem_bus.source)
   );

   writeback_stage u_writeback (
      .clk            (clk),
      .reset          (reset),
      .ex_mem         (ex_mem_bus.sink),
      .dmem_we_o      (dmem_we_o),
      .dmem_addr_o    (dmem_addr_o),
      .dmem_wdata_o   (dmem_wdata_o),
      .dmem_pc_o      (dmem_pc_o),
      .dmem_rdata_i   (dmem_rdata_i),
      .state_status_i (state_status_i),
      .read_ptr_i     (read_ptr_i),
      .wb_we_o        (wb_we),
      .wb_addr_o      (wb_addr),
      .wb_data_o      (wb_data)
   );

endmodule

`default_nettype wire

// ==== test/core_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "core_settings.svh"

module core_tb;

   localparam int ROM_DEPTH   = 2**`CORE_PC_W;
   localparam int DMEM_DEPTH  = 256;
   localparam int MAX_STORES  = 32;
   localparam int STORE_LIMIT = 300;
   localparam int DRAIN_LIMIT = 30;

   logic                      clk = 1'b0;
   logic                      reset;
   logic [`CORE_PC_W-1:0]     imem_addr_o;
   logic [31:0]               imem_data_i;
   logic                      dmem_we_o;
   logic [`CORE_XLEN-1:0]     dmem_addr_o;
   logic [`CORE_XLEN-1:0]     dmem_wdata_o;
   logic [`CORE_PC_W-1:0]     dmem_pc_o;
   logic [`CORE_XLEN-1:0]     dmem_rdata_i;
   logic [`CORE_STATUS_W-1:0] state_status_i;
   logic [`CORE_RDPTR_W-1:0]  read_ptr_i;

   // memory models
   logic [31:0]               rom [ROM_DEPTH];
   logic [`CORE_XLEN-1:0]     dmem [DMEM_DEPTH];

   // values seen in the middle of the previous cycle
   logic [`CORE_PC_W-1:0]     imem_addr_hold;
   logic [`CORE_XLEN-1:0]     dmem_addr_hold;
   logic [`CORE_XLEN-1:0]     dmem_wdata_hold;
   logic                      dmem_we_hold;

   // expected stores in program order
   logic [`CORE_XLEN-1:0]     exp_addr [MAX_STORES];
   logic [`CORE_XLEN-1:0]     exp_data [MAX_STORES];
   logic [`CORE_PC_W-1:0]     exp_pc   [MAX_STORES];
   int                        num_exp;
   int                        store_count;

   core_top DUT (
      .clk            (clk),
      .reset          (reset),
      .imem_addr_o    (imem_addr_o),
      .imem_data_i    (imem_data_i),
      .dmem_we_o      (dmem_we_o),
      .dmem_addr_o    (dmem_addr_o),
      .dmem_wdata_o   (dmem_wdata_o),
      .dmem_pc_o      (dmem_pc_o),
      .dmem_rdata_i   (dmem_rdata_i),
      .state_status_i (state_status_i),
      .read_ptr_i     (read_ptr_i)
   );

   // 4 ns period
   always #2 clk = ~clk;

   task automatic stop_on_failure();
      $display("Done: errors found");
      $fatal(1, "simulation stopped on first failure");
   endtask

   // numerical recipes constants
   function automatic logic [31:0] lcg_next(input logic [31:0] state);
      return state * 32'd1664525 + 32'd1013904223;
   endfunction

   // ---------------------------------------------------------------------------
   // memory side sampled at the falling edge and driven after the rising edge
   // ---------------------------------------------------------------------------
   always @(negedge clk) begin
      imem_addr_hold  = imem_addr_o;
      dmem_addr_hold  = dmem_addr_o;
      dmem_wdata_hold = dmem_wdata_o;
      dmem_we_hold    = dmem_we_o;
   end

   always @(posedge clk) begin
      #0.5;
      imem_data_i  = rom[imem_addr_hold];
      dmem_rdata_i = dmem[dmem_addr_hold[7:0]];
      if (dmem_we_hold) begin
         dmem[dmem_addr_hold[7:0]] = dmem_wdata_hold;
      end
   end

   // store checker looks once per cycle
   always @(negedge clk) begin
      if (reset) begin
         assert (dmem_we_o == 1'b0) else begin
            $display("data memory written while reset was held");
            stop_on_failure();
         end
      end else if (dmem_we_o) begin
         assert (store_count < num_exp) else begin
            $display("store beyond the expected list at %0t, address %h", $time, dmem_addr_o);
            stop_on_failure();
         end
         assert (dmem_addr_o == exp_addr[store_count]) else begin
            $display("ERROR %0t dmem_addr_o got %h expected %h",
                     $time, dmem_addr_o, exp_addr[store_count]);
            stop_on_failure();
         end
         assert (dmem_wdata_o == exp_data[store_count]) else begin
            $display("ERROR %0t dmem_wdata_o got %h expected %h",
                     $time, dmem_wdata_o, exp_data[store_count]);
            stop_on_failure();
         end
         assert (dmem_pc_o == exp_pc[store_count]) else begin
            $display("ERROR %0t dmem_pc_o got %h expected %h",
                     $time, dmem_pc_o, exp_pc[store_count]);
            stop_on_failure();
         end
         store_count = store_count + 1;
      end
   end

   // ---------------------------------------------------------------------------
   // stimulus file
   // ---------------------------------------------------------------------------
   task automatic load_stimulus();
      int                    fd;
      int                    rc;
      string                 line;
      byte                   tag;
      logic [`CORE_XLEN-1:0] f0;
      logic [`CORE_XLEN-1:0] f1;
      logic [`CORE_XLEN-1:0] f2;
      logic [`CORE_XLEN-1:0] f3;
      fd = $fopen("test/core_stim.txt", "r");
      if (fd == 0) begin
         $display("could not open the stimulus file test/core_stim.txt");
         stop_on_failure();
      end
      while (!$feof(fd)) begin
         line = "";
         rc = $fgets(line, fd);
         if (rc == 0 || line.len() < 3) begin
            continue;
         end
         tag = line.getc(0);
         line = line.substr(2, line.len() - 1);
         if (tag == "P") begin
            rc = $sscanf(line, "%h %h", f0, f1);
            rom[f0[`CORE_PC_W-1:0]] = f1[31:0];
         end else if (tag == "S") begin
            rc = $sscanf(line, "%h %h", f0, f1);
            state_status_i = f0[`CORE_STATUS_W-1:0];
            read_ptr_i     = f1[`CORE_RDPTR_W-1:0];
         end else if (tag == "E") begin
            rc = $sscanf(line, "%h %h %h %h", f0, f1, f2, f3);
            exp_addr[num_exp] = f1;
            exp_pc[num_exp]   = f3[`CORE_PC_W-1:0];
            // kind 0 is a literal, 1 a memory word, 2 the status, 3 the read pointer
            case (f0)
               1:       exp_data[num_exp] = dmem[f2[7:0]];
               2:       exp_data[num_exp] = `CORE_XLEN'(state_status_i);
               3:       exp_data[num_exp] = `CORE_XLEN'(read_ptr_i);
               default: exp_data[num_exp] = f2;
            endcase
            num_exp = num_exp + 1;
         end
      end
      $fclose(fd);
   endtask

   initial begin
      logic [31:0] seed;
      logic [31:0] hi;
      int          cycles;
      reset           = 1'b1;
      imem_data_i     = 32'h0000_0013;
      dmem_rdata_i    = '0;
      state_status_i  = '0;
      read_ptr_i      = '0;
      dmem_we_hold    = 1'b0;
      imem_addr_hold  = '0;
      dmem_addr_hold  = '0;
      dmem_wdata_hold = '0;
      num_exp         = 0;
      store_count     = 0;

      // rom defaults to nop
      // dmem gets lcg words mixed with the address
      seed = 32'h0630_1c9a;
      for (int i = 0; i < ROM_DEPTH; i++) begin
         rom[i] = 32'h0000_0013;
      end
      for (int i = 0; i < DMEM_DEPTH; i++) begin
         seed = lcg_next(seed);
         hi   = seed;
         seed = lcg_next(seed);
         dmem[i] = {hi, seed} ^ `CORE_XLEN'(i);
      end
      load_stimulus();

      repeat (2) @(posedge clk);
      #0.5;
      reset = 1'b0;
      @(negedge clk);
      assert (imem_addr_o == '0) else begin
         $display("ERROR %0t imem_addr_o got %h expected %h", $time, imem_addr_o, 8'h00);
         stop_on_failure();
      end

      // wait for all expected stores within a bound
      cycles = 0;
      while (store_count < num_exp && cycles < STORE_LIMIT) begin
         @(posedge clk);
         cycles = cycles + 1;
      end
      assert (store_count == num_exp) else begin
         $display("timed out with %0d of %0d stores seen", store_count, num_exp);
         stop_on_failure();
      end

      // let the program spin to catch late extra stores
      cycles = 0;
      while (cycles < DRAIN_LIMIT) begin
         @(posedge clk);
         cycles = cycles + 1;
      end

      if (store_count == num_exp) begin
         $display("Done: no errors");
         $finish;
      end else begin
         stop_on_failure();
      end
   end

endmodule

`default_nettype wire

// ==== test/core_stim.txt ====
# P word_address instruction | S status read_pointer | E kind address data pc
# E kind 0 data literal, 1 data field is source address, 2 status, 3 read pointer
P 01 12300093
P 02 FFB00113
P 03 01003283
P 04 10003303
P 05 20003383
P 06 00208433
P 07 402084B3
P 08 40115533
P 09 001125B3
P 0A 0F00C613
P 0B 03C15693
P 0C 02803023
P 0D 02903423
P 0E 02A03823
P 0F 02B03C23
P 10 04C03023
P 11 04D03423
P 12 04503823
P 13 04603C23
P 14 06703023
P 15 00208363
P 16 06C03423
P 17 00209363
P 18 06103823
P 19 06103C23
P 1A 0060006F
P 1B 08203023
P 1C 08203423
P 1D 08103823
P 1E 0000006F
S 3 A5
E 0 20 11E 0C
E 0 28 128 0D
E 0 30 FFFFFFFFFFFFFFFF 0E
E 0 38 1 0F
E 0 40 1D3 10
E 0 48 F 11
E 1 50 10 12
E 2 58 0 13
E 3 60 0 14
E 0 68 1D3 16
E 0 90 123 1D

// ==== sim.f ====
+incdir+include
logic/isa_pkg.sv
logic/pipe_pkg.sv
logic/mem_stage_if.sv
logic/fetch_unit.sv
logic/register_file.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/writeback_stage.sv
logic/core_top.sv
test/core_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# compile and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module core_tb; then
   echo "verilator compile failed"
   exit 1
fi

./obj_dir/Vcore_tb > sim.log 2>&1
run_status=$?
cat sim.log
if [ "$run_status" -ne 0 ]; then
   echo "simulation exited with status $run_status"
fi

if grep -q "Done: no errors" sim.log; then
   echo "PASS"
   exit 0
else
   echo "FAIL"
   exit 1
fi
